// File: Bender.yml
package:
  name: cpu_unit

sources:
  - hdl/cpu_cfg_pkg.sv
  - hdl/cpu_isa_pkg.sv
  - hdl/instr_sequencer.sv
  - hdl/thread_regs.sv
  - hdl/integer_ops.sv
  - hdl/cpu.sv
  - hdl/unit_output_buf.sv
  - hdl/cpu_unit.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_cpu_unit.sv

// File: hdl/cpu.sv
`timescale 1ns/1ps

module cpu (
	input  logic CLK,
	input  logic arst_n,
	input  logic [cpu_cfg_pkg::THREAD_W-1:0] thread_num,
	input  logic [cpu_isa_pkg::INSTR_W-1:0] instr,
	input  logic stage_read,
	input  logic stage_exec,
	input  logic uob_full,
	output logic executed,
	output logic jump,
	output logic next_thread,
	output logic halt,
	output logic [cpu_cfg_pkg::IADDR_W-1:0] jump_addr,
	output logic uob_wr_en,
	output logic [cpu_cfg_pkg::DATA_W-1:0] uob_data,
	output logic [cpu_cfg_pkg::THREAD_W-1:0] uob_thread
);

	cpu_isa_pkg::opcode_e op_in;

	// decoded at READ, used in EXEC
	cpu_isa_pkg::opcode_e op_r;
	cpu_isa_pkg::cond_e cond_r;
	logic [cpu_cfg_pkg::REG_W-1:0] reg_r;
	logic [cpu_isa_pkg::IMM_W-1:0] imm_r;
	logic is_wr;
	logic is_jmp;
	logic is_out;
	logic is_halt;

	logic [cpu_cfg_pkg::DATA_W-1:0] reg_dout;
	logic [cpu_cfg_pkg::DATA_W-1:0] alu_dout;
	logic zf, cf;
	logic zf_new, cf_new;
	logic zf_mask, cf_mask;

	logic cond_true;
	logic do_op;
	logic out_blocked;

	assign op_in = cpu_isa_pkg::opcode_e'(instr[cpu_isa_pkg::OPC_MSB:cpu_isa_pkg::OPC_LSB]);

	// ******************************************************************
	// decode, latched on stage_read
	// ******************************************************************
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			cond_r <= cpu_isa_pkg::ALWAYS;
			is_wr <= 1'b0;
			is_jmp <= 1'b0;
			is_out <= 1'b0;
			is_halt <= 1'b0;
		end else if (stage_read) begin
			cond_r <= cpu_isa_pkg::cond_e'(instr[cpu_isa_pkg::COND_MSB:cpu_isa_pkg::COND_LSB]);
			// opcodes that write a register
			is_wr <= op_in inside {cpu_isa_pkg::MV_R_C, cpu_isa_pkg::MV_R_TID,
				cpu_isa_pkg::ADD_R_C, cpu_isa_pkg::SUB_R_C,
				cpu_isa_pkg::AND_R_C, cpu_isa_pkg::SHR1};
			is_jmp <= op_in == cpu_isa_pkg::JMP;
			is_out <= op_in == cpu_isa_pkg::OUT_R;
			is_halt <= op_in == cpu_isa_pkg::HALT;
		end
	end

	// operand fields
	always_ff @(posedge CLK) begin
		if (stage_read) begin
			op_r <= op_in;
			reg_r <= instr[cpu_isa_pkg::REG_MSB:cpu_isa_pkg::REG_LSB];
			imm_r <= instr[cpu_isa_pkg::IMM_MSB:cpu_isa_pkg::IMM_LSB];
		end
	end

	// ******************************************************************
	// registers, flags and the ALU
	// ******************************************************************
	// register read address comes straight from the fetched word
	thread_regs u_thread_regs (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.rd_thread   (thread_num),
		.wr_thread   (thread_num),
		.rd_addr     (instr[cpu_isa_pkg::REG_MSB:cpu_isa_pkg::REG_LSB]),
		.wr_addr     (reg_r),
		.rd_en       (stage_read),
		.wr_en       (do_op & is_wr),
		.flags_wr_en (do_op & is_wr),
		.din         (alu_dout),
		.zf_in       (zf_new),
		.cf_in       (cf_new),
		.zf_mask     (zf_mask),
		.cf_mask     (cf_mask),
		.dout        (reg_dout),
		.zf          (zf),
		.cf          (cf)
	);

	integer_ops u_integer_ops (
		.opcode     (op_r),
		.dina       (reg_dout),
		.imm        (imm_r),
		.thread_num (thread_num),
		.dout       (alu_dout),
		.zf_out     (zf_new),
		.cf_out     (cf_new),
		.zf_mask    (zf_mask),
		.cf_mask    (cf_mask)
	);

	// condition against the running thread's flags
	always_comb begin
		case (cond_r)
			cpu_isa_pkg::IF_ZERO:     cond_true = zf;
			cpu_isa_pkg::IF_NOT_ZERO: cond_true = ~zf;
			cpu_isa_pkg::IF_CARRY:    cond_true = cf;
			default:                  cond_true = 1'b1;
		endcase
	end

	// ******************************************************************
	// EXEC outcome toward the sequencer and the output buffer
	// ******************************************************************
	assign do_op = stage_exec & cond_true;

	// OUT_R with a full buffer yields and retries later
	assign out_blocked = do_op & is_out & uob_full;
	assign uob_wr_en = do_op & is_out & ~uob_full;
	assign uob_data = reg_dout;
	assign uob_thread = thread_num;

	assign jump = do_op & is_jmp;
	assign jump_addr = imm_r[cpu_cfg_pkg::IADDR_W-1:0];
	assign halt = do_op & is_halt;

	// taken jump, halt or blocked output switch threads
	assign next_thread = jump | halt | out_blocked;
	// false conditions fall through to the next address
	assign executed = stage_exec & ~next_thread;

endmodule

// File: hdl/cpu_cfg_pkg.sv
package cpu_cfg_pkg;

	// ******************************************************************
	// thread and register file sizing
	// ******************************************************************
	localparam int N_THREADS = 4;
	localparam int THREAD_W = 2;
	// registers per thread
	localparam int N_REGS = 4;
	localparam int REG_W = 2;
	localparam int DATA_W = 16;

	// program memory of 2**IADDR_W instructions
	localparam int IADDR_W = 6;

	// ******************************************************************
	// output buffer and credit flow control
	// ******************************************************************
	// credits granted by the receiver at reset
	localparam int OUT_CREDITS = 4;
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(OUT_CREDITS);
	// power of two, pointers wrap naturally
	localparam int UOB_DEPTH = 4;
	localparam int UOB_PTR_W = $clog2(UOB_DEPTH);

endpackage

// File: hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// ******************************************************************
	// instruction word layout
	// ******************************************************************
	localparam int INSTR_W = 16;

	// opcode field
	localparam int OPC_MSB = 15;
	localparam int OPC_LSB = 12;
	// condition field
	localparam int COND_MSB = 11;
	localparam int COND_LSB = 10;
	// register select
	localparam int REG_MSB = 9;
	localparam int REG_LSB = 8;
	// immediate, zero-extended where it meets a register
	localparam int IMM_MSB = 7;
	localparam int IMM_LSB = 0;
	localparam int IMM_W = IMM_MSB - IMM_LSB + 1;

	// ******************************************************************
	// opcodes and conditions
	// ******************************************************************
	typedef enum logic [3:0] {
		NOP      = 4'd0,
		MV_R_C   = 4'd1,
		MV_R_TID = 4'd2,
		ADD_R_C  = 4'd3,
		SUB_R_C  = 4'd4,
		AND_R_C  = 4'd5,
		SHR1     = 4'd6,
		JMP      = 4'd7,
		OUT_R    = 4'd8,
		HALT     = 4'd9
	} opcode_e;

	// every opcode is gated by its condition
	typedef enum logic [1:0] {
		ALWAYS      = 2'd0,
		IF_ZERO     = 2'd1,
		IF_NOT_ZERO = 2'd2,
		IF_CARRY    = 2'd3
	} cond_e;

	// sequencer states, one instruction in flight
	typedef enum logic [2:0] {
		IDLE   = 3'd0,
		FETCH  = 3'd1,
		READ   = 3'd2,
		EXEC   = 3'd3,
		SWITCH = 3'd4
	} seq_state_e;

endpackage

// File: hdl/cpu_unit.sv
`timescale 1ns/1ps

module cpu_unit (
	input  logic CLK,
	input  logic arst_n,
	input  logic start,
	input  logic prog_wr_en,
	input  logic [cpu_cfg_pkg::IADDR_W-1:0] prog_wr_addr,
	input  logic [cpu_isa_pkg::INSTR_W-1:0] prog_wr_data,
	input  logic out_credit,
	output logic done,
	output logic out_valid,
	output logic [cpu_cfg_pkg::DATA_W-1:0] out_data,
	output logic [cpu_cfg_pkg::THREAD_W-1:0] out_thread
);

	// sequencer to cpu
	logic [cpu_isa_pkg::INSTR_W-1:0] instr;
	logic [cpu_cfg_pkg::THREAD_W-1:0] thread_num;
	logic stage_read, stage_exec;
	// cpu back to the sequencer
	logic executed, jump, next_thread, halt;
	logic [cpu_cfg_pkg::IADDR_W-1:0] jump_addr;
	// cpu to the output buffer
	logic uob_wr_en, uob_full, uob_empty;
	logic [cpu_cfg_pkg::DATA_W-1:0] uob_data;
	logic [cpu_cfg_pkg::THREAD_W-1:0] uob_thread;

	instr_sequencer u_instr_sequencer (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.start        (start),
		.prog_wr_en   (prog_wr_en),
		.prog_wr_addr (prog_wr_addr),
		.prog_wr_data (prog_wr_data),
		.executed     (executed),
		.jump         (jump),
		.next_thread  (next_thread),
		.halt         (halt),
		.jump_addr    (jump_addr),
		.uob_empty    (uob_empty),
		.instr        (instr),
		.thread_num   (thread_num),
		.stage_read   (stage_read),
		.stage_exec   (stage_exec),
		.done         (done)
	);

	cpu u_cpu (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.thread_num  (thread_num),
		.instr       (instr),
		.stage_read  (stage_read),
		.stage_exec  (stage_exec),
		.uob_full    (uob_full),
		.executed    (executed),
		.jump        (jump),
		.next_thread (next_thread),
		.halt        (halt),
		.jump_addr   (jump_addr),
		.uob_wr_en   (uob_wr_en),
		.uob_data    (uob_data),
		.uob_thread  (uob_thread)
	);

	unit_output_buf u_unit_output_buf (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.wr_en      (uob_wr_en),
		.din        (uob_data),
		.din_thread (uob_thread),
		.out_credit (out_credit),
		.full       (uob_full),
		.empty      (uob_empty),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_thread (out_thread)
	);

endmodule

// File: hdl/instr_sequencer.sv
`timescale 1ns/1ps

module instr_sequencer (
	input  logic CLK,
	input  logic arst_n,
	input  logic start,
	input  logic prog_wr_en,
	input  logic [cpu_cfg_pkg::IADDR_W-1:0] prog_wr_addr,
	input  logic [cpu_isa_pkg::INSTR_W-1:0] prog_wr_data,
	input  logic executed,
	input  logic jump,
	input  logic next_thread,
	input  logic halt,
	input  logic [cpu_cfg_pkg::IADDR_W-1:0] jump_addr,
	input  logic uob_empty,
	output logic [cpu_isa_pkg::INSTR_W-1:0] instr,
	output logic [cpu_cfg_pkg::THREAD_W-1:0] thread_num,
	output logic stage_read,
	output logic stage_exec,
	output logic done
);

	// program shared by all threads
	logic [cpu_isa_pkg::INSTR_W-1:0] prog_mem [2**cpu_cfg_pkg::IADDR_W];
	logic [cpu_cfg_pkg::IADDR_W-1:0] pc [cpu_cfg_pkg::N_THREADS];
	logic [cpu_cfg_pkg::N_THREADS-1:0] halted;

	cpu_isa_pkg::seq_state_e state;
	// all threads halted, waiting for the output FIFO to drain
	logic draining;

	logic next_found;
	logic [cpu_cfg_pkg::THREAD_W-1:0] next_tid;

	assign stage_read = state == cpu_isa_pkg::READ;
	assign stage_exec = state == cpu_isa_pkg::EXEC;

	// ******************************************************************
	// round-robin pick, starting after the current thread
	// ******************************************************************
	// the current thread is checked last so a lone survivor keeps running
	always_comb begin
		logic [cpu_cfg_pkg::THREAD_W-1:0] cand;
		next_found = 1'b0;
		next_tid = thread_num;
		for (int i = 1; i <= cpu_cfg_pkg::N_THREADS; i++) begin
			cand = thread_num + i[cpu_cfg_pkg::THREAD_W-1:0];
			if (!next_found && !halted[cand]) begin
				next_found = 1'b1;
				next_tid = cand;
			end
		end
	end

	// program load only while idle, fetch registered into instr
	always_ff @(posedge CLK) begin
		if (prog_wr_en && state == cpu_isa_pkg::IDLE)
			prog_mem[prog_wr_addr] <= prog_wr_data;
		if (state == cpu_isa_pkg::FETCH)
			instr <= prog_mem[pc[thread_num]];
	end

	// ******************************************************************
	// sequencer FSM
	// ******************************************************************
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= cpu_isa_pkg::IDLE;
			thread_num <= '0;
			halted <= '0;
			draining <= 1'b0;
			done <= 1'b0;
			for (int t = 0; t < cpu_cfg_pkg::N_THREADS; t++)
				pc[t] <= '0;
		end else begin
			case (state)
				cpu_isa_pkg::IDLE: begin
					if (start) begin
						// fresh run, thread 0 from address 0
						state <= cpu_isa_pkg::FETCH;
						thread_num <= '0;
						halted <= '0;
						draining <= 1'b0;
						done <= 1'b0;
						for (int t = 0; t < cpu_cfg_pkg::N_THREADS; t++)
							pc[t] <= '0;
					end else if (draining && uob_empty) begin
						draining <= 1'b0;
						done <= 1'b1;
					end
				end
				cpu_isa_pkg::FETCH:
					state <= cpu_isa_pkg::READ;
				cpu_isa_pkg::READ:
					state <= cpu_isa_pkg::EXEC;
				cpu_isa_pkg::EXEC: begin
					if (halt)
						halted[thread_num] <= 1'b1;
					// a blocked OUT_R leaves the counter in place for a retry
					if (jump)
						pc[thread_num] <= jump_addr;
					else if (executed)
						pc[thread_num] <= pc[thread_num] + 1'b1;
					state <= next_thread ? cpu_isa_pkg::SWITCH : cpu_isa_pkg::FETCH;
				end
				cpu_isa_pkg::SWITCH: begin
					if (next_found) begin
						thread_num <= next_tid;
						state <= cpu_isa_pkg::FETCH;
					end else begin
						draining <= 1'b1;
						state <= cpu_isa_pkg::IDLE;
					end
				end
				default:
					state <= cpu_isa_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: hdl/integer_ops.sv
`timescale 1ns/1ps

module integer_ops (
	input  cpu_isa_pkg::opcode_e opcode,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] dina,
	input  logic [cpu_isa_pkg::IMM_W-1:0] imm,
	input  logic [cpu_cfg_pkg::THREAD_W-1:0] thread_num,
	output logic [cpu_cfg_pkg::DATA_W-1:0] dout,
	output logic zf_out,
	output logic cf_out,
	output logic zf_mask,
	output logic cf_mask
);

	logic [cpu_cfg_pkg::DATA_W-1:0] imm_ext;
	logic [cpu_cfg_pkg::DATA_W-1:0] tid_ext;
	// one extra bit holds carry or borrow
	logic [cpu_cfg_pkg::DATA_W:0] sum;

	assign imm_ext = {{(cpu_cfg_pkg::DATA_W - cpu_isa_pkg::IMM_W){1'b0}}, imm};
	assign tid_ext = {{(cpu_cfg_pkg::DATA_W - cpu_cfg_pkg::THREAD_W){1'b0}}, thread_num};

	always_comb begin
		sum = {1'b0, dina} + {1'b0, imm_ext};
		dout = dina;
		cf_out = sum[cpu_cfg_pkg::DATA_W];
		zf_mask = 1'b0;
		cf_mask = 1'b0;
		case (opcode)
			cpu_isa_pkg::MV_R_C:
				dout = imm_ext;
			cpu_isa_pkg::MV_R_TID:
				dout = tid_ext;
			cpu_isa_pkg::ADD_R_C: begin
				dout = sum[cpu_cfg_pkg::DATA_W-1:0];
				zf_mask = 1'b1;
				cf_mask = 1'b1;
			end
			cpu_isa_pkg::SUB_R_C: begin
				// top bit set means borrow
				sum = {1'b0, dina} - {1'b0, imm_ext};
				dout = sum[cpu_cfg_pkg::DATA_W-1:0];
				cf_out = sum[cpu_cfg_pkg::DATA_W];
				zf_mask = 1'b1;
				cf_mask = 1'b1;
			end
			cpu_isa_pkg::AND_R_C: begin
				dout = dina & imm_ext;
				zf_mask = 1'b1;
			end
			cpu_isa_pkg::SHR1: begin
				// shifted-out bit goes to carry
				dout = dina >> 1;
				cf_out = dina[0];
				zf_mask = 1'b1;
				cf_mask = 1'b1;
			end
			default: ;
		endcase
		zf_out = dout == '0;
	end

endmodule

// File: hdl/thread_regs.sv
`timescale 1ns/1ps

module thread_regs (
	input  logic CLK,
	input  logic arst_n,
	input  logic [cpu_cfg_pkg::THREAD_W-1:0] rd_thread,
	input  logic [cpu_cfg_pkg::THREAD_W-1:0] wr_thread,
	input  logic [cpu_cfg_pkg::REG_W-1:0] rd_addr,
	input  logic [cpu_cfg_pkg::REG_W-1:0] wr_addr,
	input  logic rd_en,
	input  logic wr_en,
	input  logic flags_wr_en,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] din,
	input  logic zf_in,
	input  logic cf_in,
	input  logic zf_mask,
	input  logic cf_mask,
	output logic [cpu_cfg_pkg::DATA_W-1:0] dout,
	output logic zf,
	output logic cf
);

	// registers addressed by {thread, reg}
	logic [cpu_cfg_pkg::DATA_W-1:0] regs [cpu_cfg_pkg::N_THREADS * cpu_cfg_pkg::N_REGS];
	logic [cpu_cfg_pkg::N_THREADS-1:0] zf_r;
	logic [cpu_cfg_pkg::N_THREADS-1:0] cf_r;

	// read lands in EXEC, write at the edge that ends EXEC
	always_ff @(posedge CLK) begin
		if (wr_en)
			regs[{wr_thread, wr_addr}] <= din;
		if (rd_en)
			dout <= regs[{rd_thread, rd_addr}];
	end

	// each flag only where the opcode defines it
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			zf_r <= '0;
			cf_r <= '0;
		end else if (flags_wr_en) begin
			if (zf_mask)
				zf_r[wr_thread] <= zf_in;
			if (cf_mask)
				cf_r[wr_thread] <= cf_in;
		end
	end

	// flags of the running thread, seen by the condition check
	assign zf = zf_r[rd_thread];
	assign cf = cf_r[rd_thread];

endmodule

// File: hdl/unit_output_buf.sv
`timescale 1ns/1ps

module unit_output_buf (
	input  logic CLK,
	input  logic arst_n,
	input  logic wr_en,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] din,
	input  logic [cpu_cfg_pkg::THREAD_W-1:0] din_thread,
	input  logic out_credit,
	output logic full,
	output logic empty,
	output logic out_valid,
	output logic [cpu_cfg_pkg::DATA_W-1:0] out_data,
	output logic [cpu_cfg_pkg::THREAD_W-1:0] out_thread
);

	// data and thread tag stored side by side
	logic [cpu_cfg_pkg::DATA_W-1:0] data_mem [cpu_cfg_pkg::UOB_DEPTH];
	logic [cpu_cfg_pkg::THREAD_W-1:0] tag_mem [cpu_cfg_pkg::UOB_DEPTH];
	logic [cpu_cfg_pkg::UOB_PTR_W-1:0] wr_ptr, rd_ptr;
	logic [cpu_cfg_pkg::UOB_PTR_W:0] count;
	logic [cpu_cfg_pkg::CREDIT_W-1:0] credit;
	logic push, pop;

	assign full = count == cpu_cfg_pkg::UOB_DEPTH;
	assign empty = count == '0;
	assign push = wr_en & ~full;

	// one word per cycle while data and credit are both present
	assign out_valid = ~empty & (credit != '0);
	assign pop = out_valid;
	assign out_data = data_mem[rd_ptr];
	assign out_thread = tag_mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (push) begin
			data_mem[wr_ptr] <= din;
			tag_mem[wr_ptr] <= din_thread;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= cpu_cfg_pkg::CREDIT_MAX;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// spend on send, refill on credit return, capped at the grant
			if (pop && !out_credit)
				credit <= credit - 1'b1;
			else if (out_credit && !pop && credit != cpu_cfg_pkg::CREDIT_MAX)
				credit <= credit + 1'b1;
		end
	end

endmodule

// File: sim.f
hdl/cpu_cfg_pkg.sv
hdl/cpu_isa_pkg.sv
hdl/instr_sequencer.sv
hdl/thread_regs.sv
hdl/integer_ops.sv
hdl/cpu.sv
hdl/unit_output_buf.sv
hdl/cpu_unit.sv
testbench/tb_clock.sv
testbench/tb_cpu_unit.sv

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic arst_n
);

	// 8 ns period
	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// reset held for 4 cycles, released just after an edge
	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge CLK);
		#1;
		arst_n = 1'b1;
	end

endmodule

// File: testbench/tb_cpu_unit.sv
`timescale 1ns/1ps

module tb_cpu_unit;

	localparam int NT = cpu_cfg_pkg::N_THREADS;
	localparam int PROG_LEN = 13;
	// long credit stall, well past the time the FIFO needs to fill
	localparam int STALL_CYC = 200;
	// threads x instructions x cycles x margin, plus the stall
	localparam int RUN_LIMIT = NT * 20 * 4 * 4 + STALL_CYC;

	logic CLK, arst_n;
	logic start, prog_wr_en, out_credit;
	logic [cpu_cfg_pkg::IADDR_W-1:0] prog_wr_addr;
	logic [cpu_isa_pkg::INSTR_W-1:0] prog_wr_data;
	logic done, out_valid;
	logic [cpu_cfg_pkg::DATA_W-1:0] out_data;
	logic [cpu_cfg_pkg::THREAD_W-1:0] out_thread;

	logic [15:0] prog [PROG_LEN];
	// model output per thread
	logic [15:0] exp_words [NT][16];
	int exp_cnt [NT];
	int got_cnt [NT];

	int errors = 0;
	int tests_pass = 0;
	int tests_fail = 0;
	int outstanding = 0;
	int pending = 0;
	int total_seen = 0;
	int run_cycles = 0;
	bit run_active = 1'b0;
	bit before_start = 1'b1;
	bit stall_armed = 1'b0;
	bit done_prev = 1'b0;
	bit done_hold = 1'b0;

	tb_clock u_tb_clock (.CLK(CLK), .arst_n(arst_n));

	cpu_unit u_cpu_unit (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.start        (start),
		.prog_wr_en   (prog_wr_en),
		.prog_wr_addr (prog_wr_addr),
		.prog_wr_data (prog_wr_data),
		.out_credit   (out_credit),
		.done         (done),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.out_thread   (out_thread)
	);

	// ******************************************************************
	// program image and reference model
	// ******************************************************************
	function automatic logic [15:0] encode_instr(input cpu_isa_pkg::opcode_e op,
		input cpu_isa_pkg::cond_e cond, input logic [1:0] rg, input logic [7:0] imm);
		return {op, cond, rg, imm};
	endfunction

	task automatic build_program();
		prog[0] = encode_instr(cpu_isa_pkg::MV_R_TID, cpu_isa_pkg::ALWAYS, 2'd0, 8'h00);
		prog[1] = encode_instr(cpu_isa_pkg::MV_R_C, cpu_isa_pkg::ALWAYS, 2'd1, 8'h03);
		// loop body at 2
		prog[2] = encode_instr(cpu_isa_pkg::OUT_R, cpu_isa_pkg::ALWAYS, 2'd0, 8'h00);
		prog[3] = encode_instr(cpu_isa_pkg::ADD_R_C, cpu_isa_pkg::ALWAYS, 2'd0, 8'h05);
		prog[4] = encode_instr(cpu_isa_pkg::SUB_R_C, cpu_isa_pkg::ALWAYS, 2'd1, 8'h01);
		prog[5] = encode_instr(cpu_isa_pkg::JMP, cpu_isa_pkg::IF_NOT_ZERO, 2'd0, 8'h02);
		prog[6] = encode_instr(cpu_isa_pkg::AND_R_C, cpu_isa_pkg::ALWAYS, 2'd0, 8'h0f);
		prog[7] = encode_instr(cpu_isa_pkg::OUT_R, cpu_isa_pkg::ALWAYS, 2'd0, 8'h00);
		prog[8] = encode_instr(cpu_isa_pkg::SHR1, cpu_isa_pkg::ALWAYS, 2'd0, 8'h00);
		// carry out of the shift selects the extra output
		prog[9] = encode_instr(cpu_isa_pkg::JMP, cpu_isa_pkg::IF_CARRY, 2'd0, 8'h0b);
		prog[10] = encode_instr(cpu_isa_pkg::HALT, cpu_isa_pkg::ALWAYS, 2'd0, 8'h00);
		prog[11] = encode_instr(cpu_isa_pkg::OUT_R, cpu_isa_pkg::ALWAYS, 2'd1, 8'h00);
		prog[12] = encode_instr(cpu_isa_pkg::HALT, cpu_isa_pkg::ALWAYS, 2'd0, 8'h00);
	endtask

	// runs one thread through the program, collecting its OUT_R words
	task automatic model_thread(input int t);
		logic [15:0] r [4];
		logic [16:0] wide;
		logic [15:0] imm;
		logic zf, cf, take;
		cpu_isa_pkg::opcode_e op;
		int pc, next_pc, rs, steps;
		bit running;
		for (int i = 0; i < 4; i++)
			r[i] = '0;
		zf = 1'b0;
		cf = 1'b0;
		pc = 0;
		steps = 0;
		running = 1'b1;
		exp_cnt[t] = 0;
		while (running && steps < 64 && pc < PROG_LEN) begin
			op = cpu_isa_pkg::opcode_e'(prog[pc][15:12]);
			rs = prog[pc][9:8];
			imm = {8'h00, prog[pc][7:0]};
			case (prog[pc][11:10])
				2'd0: take = 1'b1;
				2'd1: take = zf;
				2'd2: take = ~zf;
				default: take = cf;
			endcase
			next_pc = pc + 1;
			steps++;
			if (take) begin
				case (op)
					cpu_isa_pkg::MV_R_C: r[rs] = imm;
					cpu_isa_pkg::MV_R_TID: r[rs] = 16'(t);
					cpu_isa_pkg::ADD_R_C: begin
						wide = {1'b0, r[rs]} + {1'b0, imm};
						r[rs] = wide[15:0];
						zf = r[rs] == 16'h0;
						cf = wide[16];
					end
					cpu_isa_pkg::SUB_R_C: begin
						// borrow shows in the top bit
						wide = {1'b0, r[rs]} - {1'b0, imm};
						r[rs] = wide[15:0];
						zf = r[rs] == 16'h0;
						cf = wide[16];
					end
					cpu_isa_pkg::AND_R_C: begin
						r[rs] = r[rs] & imm;
						zf = r[rs] == 16'h0;
					end
					cpu_isa_pkg::SHR1: begin
						cf = r[rs][0];
						r[rs] = r[rs] >> 1;
						zf = r[rs] == 16'h0;
					end
					cpu_isa_pkg::JMP: next_pc = int'(imm[5:0]);
					cpu_isa_pkg::OUT_R: begin
						exp_words[t][exp_cnt[t]] = r[rs];
						exp_cnt[t]++;
					end
					cpu_isa_pkg::HALT: running = 1'b0;
					default: ;
				endcase
			end
			pc = next_pc;
		end
	endtask

	// ******************************************************************
	// stimulus tasks
	// ******************************************************************
	task automatic load_program();
		for (int a = 0; a < PROG_LEN; a++) begin
			@(posedge CLK);
			#1;
			prog_wr_en = 1'b1;
			prog_wr_addr = a[cpu_cfg_pkg::IADDR_W-1:0];
			prog_wr_data = prog[a];
		end
		@(posedge CLK);
		#1;
		prog_wr_en = 1'b0;
	endtask

	task automatic start_run();
		@(posedge CLK);
		#1;
		for (int t = 0; t < NT; t++)
			got_cnt[t] = 0;
		total_seen = 0;
		before_start = 1'b0;
		done_hold = 1'b0;
		run_cycles = 0;
		run_active = 1'b1;
		start = 1'b1;
		@(posedge CLK);
		#1;
		start = 1'b0;
		// watchdog below ends the run if done never comes
		wait (done_hold);
		run_active = 1'b0;
		// done must hold and no late word may appear
		repeat (12) @(posedge CLK);
		for (int t = 0; t < NT; t++) begin
			assert (got_cnt[t] == exp_cnt[t]) else begin
				$display("thread %0d delivered %0d words, model expects %0d",
					t, got_cnt[t], exp_cnt[t]);
				errors++;
			end
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_pass++;
			$display("test %0d %s: pass", num, name);
		end else begin
			tests_fail++;
			$display("test %0d %s: fail, %0d errors", num, name, errors - errs_before);
		end
	endtask

	// ******************************************************************
	// credit return, one per accepted word after a random gap
	// ******************************************************************
	initial begin
		int hold;
		out_credit = 1'b0;
		hold = 0;
		@(posedge arst_n);
		forever begin
			@(posedge CLK);
			#1;
			out_credit = 1'b0;
			if (stall_armed && total_seen >= 2) begin
				stall_armed = 1'b0;
				hold = STALL_CYC;
			end
			if (hold > 0)
				hold--;
			else if (pending > 0) begin
				out_credit = 1'b1;
				pending--;
				hold = $urandom % 4;
			end
		end
	end

	// ******************************************************************
	// output monitor, sampled at the falling edge
	// ******************************************************************
	always @(negedge CLK) begin
		int thr;
		if (arst_n) begin
			if (before_start) begin
				assert (!out_valid) else begin
					$display("ERR out_valid: got %h, expected 0 before start", out_valid);
					errors++;
				end
				assert (!done) else begin
					$display("ERR done: got %h, expected 0 before start", done);
					errors++;
				end
			end
			if (out_valid) begin
				// a word goes out only with a credit in hand
				assert (outstanding < cpu_cfg_pkg::OUT_CREDITS) else begin
					$display("word sent with %0d credits already outstanding", outstanding);
					errors++;
				end
				thr = out_thread;
				assert (got_cnt[thr] < exp_cnt[thr]) else begin
					$display("extra word from thread %0d beyond the model's %0d",
						thr, exp_cnt[thr]);
					errors++;
				end
				if (got_cnt[thr] < exp_cnt[thr]) begin
					assert (out_data == exp_words[thr][got_cnt[thr]]) else begin
						$display("ERR out_data thread %0d word %0d: got %h, expected %h",
							thr, got_cnt[thr], out_data, exp_words[thr][got_cnt[thr]]);
						errors++;
					end
				end
				got_cnt[thr]++;
				total_seen++;
				pending++;
			end
			outstanding = outstanding + int'(out_valid) - int'(out_credit);
			// done rising means every expected word is already out
			if (done && !done_prev && !before_start) begin
				done_hold = 1'b1;
				for (int t = 0; t < NT; t++) begin
					assert (got_cnt[t] == exp_cnt[t]) else begin
						$display("done rose with thread %0d at %0d of %0d words",
							t, got_cnt[t], exp_cnt[t]);
						errors++;
					end
				end
			end
			if (done_hold) begin
				assert (done) else begin
					$display("ERR done: got %h, expected 1 until the next start", done);
					errors++;
				end
			end
			done_prev = done;
		end
	end

	// ******************************************************************
	// watchdog
	// ******************************************************************
	always @(posedge CLK) begin
		if (run_active)
			run_cycles <= run_cycles + 1;
	end

	initial begin
		wait (run_cycles > RUN_LIMIT);
		$display("timeout: done did not rise within %0d cycles", RUN_LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	// ******************************************************************
	// test sequence
	// ******************************************************************
	initial begin
		int e0;
		void'($urandom(32'hef26));
		start = 1'b0;
		prog_wr_en = 1'b0;
		prog_wr_addr = '0;
		prog_wr_data = '0;
		build_program();
		for (int t = 0; t < NT; t++)
			model_thread(t);
		@(posedge arst_n);

		// quiet outputs through reset and program load
		e0 = errors;
		load_program();
		repeat (8) @(posedge CLK);
		report_test(1, "reset and load", e0);

		// first run with a long credit stall
		e0 = errors;
		stall_armed = 1'b1;
		start_run();
		report_test(2, "run with credit stall", e0);

		// same program again, same sequences
		e0 = errors;
		start_run();
		report_test(3, "second run", e0);

		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_pass + tests_fail, tests_pass, tests_fail, errors);
		if (errors == 0 && tests_fail == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
